//--- build.f
+incdir+src
src/serial_bus_pkg.sv
src/serial_link_if.sv
src/bus_arbiter.sv
src/init_port.sv
src/addr_decoder.sv
src/target_port.sv
src/serial_bus.sv
verification/tb_serial_bus.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_serial_bus -f build.f
./obj_dir/Vtb_serial_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- verification/tb_serial_bus.sv
`timescale 1ns/100ps

module tb_serial_bus
    import serial_bus_pkg::*;
();

    localparam int TXN_PER_INIT   = 40;
    localparam int TXN_TOTAL      = 2 * TXN_PER_INIT;
    // 24 forward bits, 8 return bits, 5 delay, 20 slack per transaction
    localparam int TIMEOUT_CYCLES = TXN_TOTAL * (24 + 8 + 5 + 20);

    logic      clk;
    logic      rst_n;
    logic      init_req[2];
    bus_addr_t init_addr[2];
    bus_data_t init_wdata[2];
    logic      init_rw[2];
    logic      init_ack[2];
    bus_data_t init_rdata[2];
    logic      tgt_req[2];
    bus_addr_t tgt_addr[2];
    bus_data_t tgt_wdata[2];
    logic      tgt_rw[2];
    logic      tgt_ack[2];
    bus_data_t tgt_rdata[2];

    // Outstanding request per initiator
    bus_addr_t cur_addr[2];
    bus_data_t cur_wdata[2];
    logic      cur_rw[2];
    logic      active[2];
    logic      served[2];
    bus_data_t rdata_exp[2];
    int        req_cycle[2];

    // Target memories indexed by address bits 7..0
    bus_data_t mem[2][256];
    logic      written[2][256];

    logic        ack_seen[2];
    logic        req_seen[2];
    int          prev_owner;
    int          txn_count;
    int          ack_count;
    int          cycle;
    logic [31:0] rng_state;

    serial_bus u_dut (
        .clk(clk), .rst_n(rst_n),
        .init_req_0(init_req[0]), .init_addr_0(init_addr[0]),
        .init_wdata_0(init_wdata[0]), .init_rw_0(init_rw[0]),
        .init_ack_0(init_ack[0]), .init_rdata_0(init_rdata[0]),
        .init_req_1(init_req[1]), .init_addr_1(init_addr[1]),
        .init_wdata_1(init_wdata[1]), .init_rw_1(init_rw[1]),
        .init_ack_1(init_ack[1]), .init_rdata_1(init_rdata[1]),
        .tgt_req_0(tgt_req[0]), .tgt_addr_0(tgt_addr[0]),
        .tgt_wdata_0(tgt_wdata[0]), .tgt_rw_0(tgt_rw[0]),
        .tgt_ack_0(tgt_ack[0]), .tgt_rdata_0(tgt_rdata[0]),
        .tgt_req_1(tgt_req[1]), .tgt_addr_1(tgt_addr[1]),
        .tgt_wdata_1(tgt_wdata[1]), .tgt_rw_1(tgt_rw[1]),
        .tgt_ack_1(tgt_ack[1]), .tgt_rdata_1(tgt_rdata[1])
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: transactions did not complete");
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // Rising handshake edges counted apart from the models
    always @(negedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (init_ack[k] && !ack_seen[k]) begin
                ack_count++;
            end
            if (tgt_req[k] && !req_seen[k]) begin
                txn_count++;
            end
            ack_seen[k] = init_ack[k];
            req_seen[k] = tgt_req[k];
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Upper bits of the LCG are the better ones
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input bus_addr_t exp, input bus_addr_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_outputs_low();
        for (int k = 0; k < 2; k++) begin
            check_bit($sformatf("init_ack_%0d", k), 1'b0, init_ack[k]);
            check_bit($sformatf("tgt_req_%0d", k), 1'b0, tgt_req[k]);
        end
    endtask

    task automatic run_initiator(input int k);
        logic [31:0] r;
        int          hold;
        for (int n = 0; n < TXN_PER_INIT; n++) begin
            repeat (rand_below(6)) @(negedge clk);
            r = next_rand();
            cur_addr[k]    = r[31:16];
            // Bit 0 names the owner on the target side
            cur_addr[k][0] = k[0];
            r = next_rand();
            cur_wdata[k]  = r[31:24];
            cur_rw[k]     = r[23];
            served[k]     = 1'b0;
            active[k]     = 1'b1;
            req_cycle[k]  = cycle;
            init_addr[k]  = cur_addr[k];
            init_wdata[k] = cur_wdata[k];
            init_rw[k]    = cur_rw[k];
            init_req[k]   = 1'b1;
            @(negedge clk);
            while (!init_ack[k]) @(negedge clk);
            if (!served[k]) begin
                stop_with_error($sformatf("init_ack_%0d rose with no target transaction", k));
            end
            active[k] = 1'b0;
            hold = rand_below(6);
            for (int h = 0; h <= hold; h++) begin
                if (h > 0) @(negedge clk);
                check_bit($sformatf("init_ack_%0d", k), 1'b1, init_ack[k]);
                if (!cur_rw[k]) begin
                    check_data($sformatf("init_rdata_%0d", k), rdata_exp[k], init_rdata[k]);
                end
            end
            init_req[k] = 1'b0;
            @(negedge clk);
            while (init_ack[k]) @(negedge clk);
        end
    endtask

    task automatic run_target(input int t);
        int          owner;
        int          delay;
        logic [7:0]  idx;
        logic [31:0] r;
        forever begin
            @(negedge clk);
            if (tgt_req[t]) begin
                owner = int'(tgt_addr[t][0]);
                if (!active[owner] || served[owner]) begin
                    stop_with_error($sformatf("tgt_req_%0d with no unserved request", t));
                end
                // The same owner twice only if the other side was not waiting
                if (prev_owner == owner && active[1-owner] && !served[1-owner] &&
                        req_cycle[1-owner] <= req_cycle[owner]) begin
                    stop_with_error($sformatf("initiator %0d won the bus while initiator %0d waited",
                                              owner, 1 - owner));
                end
                prev_owner = owner;
                check_bit("target select", cur_addr[owner][15], t[0]);
                check_addr($sformatf("tgt_addr_%0d", t), cur_addr[owner], tgt_addr[t]);
                check_bit($sformatf("tgt_rw_%0d", t), cur_rw[owner], tgt_rw[t]);
                idx = cur_addr[owner][7:0];
                if (cur_rw[owner]) begin
                    check_data($sformatf("tgt_wdata_%0d", t), cur_wdata[owner], tgt_wdata[t]);
                    mem[t][idx]     = tgt_wdata[t];
                    written[t][idx] = 1'b1;
                end else if (written[t][idx]) begin
                    rdata_exp[owner] = mem[t][idx];
                end else begin
                    r = next_rand();
                    rdata_exp[owner] = r[31:24];
                end
                served[owner] = 1'b1;
                delay = rand_below(6);
                repeat (delay) begin
                    @(negedge clk);
                    check_bit($sformatf("tgt_req_%0d", t), 1'b1, tgt_req[t]);
                end
                tgt_rdata[t] = rdata_exp[owner];
                tgt_ack[t]   = 1'b1;
                @(negedge clk);
                while (tgt_req[t]) @(negedge clk);
                tgt_ack[t] = 1'b0;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        rng_state  = 32'd69;
        prev_owner = -1;
        txn_count  = 0;
        ack_count  = 0;
        for (int k = 0; k < 2; k++) begin
            init_req[k]   = 1'b0;
            init_addr[k]  = '0;
            init_wdata[k] = '0;
            init_rw[k]    = 1'b0;
            tgt_ack[k]    = 1'b0;
            tgt_rdata[k]  = '0;
            active[k]     = 1'b0;
            served[k]     = 1'b0;
            ack_seen[k]   = 1'b0;
            req_seen[k]   = 1'b0;
            for (int a = 0; a < 256; a++) begin
                written[k][a] = 1'b0;
            end
        end
        repeat (2) begin
            @(negedge clk);
            check_outputs_low();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_outputs_low();
        fork
            run_target(0);
            run_target(1);
        join_none
        fork
            run_initiator(0);
            run_initiator(1);
        join
        if (txn_count == TXN_TOTAL && ack_count == TXN_TOTAL) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("%0d target transactions and %0d acknowledges, expected %0d",
                     txn_count, ack_count, TXN_TOTAL);
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

//--- src/serial_bus.sv
`timescale 1ns/100ps

module serial_bus
    import serial_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init_req_0,
    input  bus_addr_t init_addr_0,
    input  bus_data_t init_wdata_0,
    input  logic      init_rw_0,
    output logic      init_ack_0,
    output bus_data_t init_rdata_0,
    input  logic      init_req_1,
    input  bus_addr_t init_addr_1,
    input  bus_data_t init_wdata_1,
    input  logic      init_rw_1,
    output logic      init_ack_1,
    output bus_data_t init_rdata_1,
    output logic      tgt_req_0,
    output bus_addr_t tgt_addr_0,
    output bus_data_t tgt_wdata_0,
    output logic      tgt_rw_0,
    input  logic      tgt_ack_0,
    input  bus_data_t tgt_rdata_0,
    output logic      tgt_req_1,
    output bus_addr_t tgt_addr_1,
    output bus_data_t tgt_wdata_1,
    output logic      tgt_rw_1,
    input  logic      tgt_ack_1,
    input  bus_data_t tgt_rdata_1
);

    logic bus_req0;
    logic bus_req1;
    logic grant0;
    logic grant1;

    serial_link_if init_link0 ();
    serial_link_if init_link1 ();
    serial_link_if shared_link ();
    serial_link_if tgt_link0 ();
    serial_link_if tgt_link1 ();

    init_port u_init_port_0 (
        .clk(clk), .rst_n(rst_n), .init_req(init_req_0), .init_addr(init_addr_0),
        .init_wdata(init_wdata_0), .init_rw(init_rw_0), .grant(grant0),
        .bus_req(bus_req0), .init_ack(init_ack_0), .init_rdata(init_rdata_0),
        .link(init_link0)
    );

    init_port u_init_port_1 (
        .clk(clk), .rst_n(rst_n), .init_req(init_req_1), .init_addr(init_addr_1),
        .init_wdata(init_wdata_1), .init_rw(init_rw_1), .grant(grant1),
        .bus_req(bus_req1), .init_ack(init_ack_1), .init_rdata(init_rdata_1),
        .link(init_link1)
    );

    bus_arbiter u_bus_arbiter (
        .clk(clk), .rst_n(rst_n), .bus_req0(bus_req0), .bus_req1(bus_req1),
        .grant0(grant0), .grant1(grant1), .init_link0(init_link0),
        .init_link1(init_link1), .shared_link(shared_link)
    );

    addr_decoder u_addr_decoder (
        .clk(clk), .rst_n(rst_n), .shared_link(shared_link),
        .tgt_link0(tgt_link0), .tgt_link1(tgt_link1)
    );

    target_port u_target_port_0 (
        .clk(clk), .rst_n(rst_n), .tgt_ack(tgt_ack_0), .tgt_rdata(tgt_rdata_0),
        .tgt_req(tgt_req_0), .tgt_addr(tgt_addr_0), .tgt_wdata(tgt_wdata_0),
        .tgt_rw(tgt_rw_0), .link(tgt_link0)
    );

    target_port u_target_port_1 (
        .clk(clk), .rst_n(rst_n), .tgt_ack(tgt_ack_1), .tgt_rdata(tgt_rdata_1),
        .tgt_req(tgt_req_1), .tgt_addr(tgt_addr_1), .tgt_wdata(tgt_wdata_1),
        .tgt_rw(tgt_rw_1), .link(tgt_link1)
    );

endmodule

//--- src/target_port.sv
`timescale 1ns/100ps
`include "serial_bus_macros.svh"

module target_port
    import serial_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tgt_ack,
    input  bus_data_t tgt_rdata,
    output logic      tgt_req,
    output bus_addr_t tgt_addr,
    output bus_data_t tgt_wdata,
    output logic      tgt_rw,
    serial_link_if.target link
);

    typedef enum logic [1:0] {
        S_RECV,
        S_REQ,
        S_RET,
        S_DONE
    } state_e;

    state_e    state;
    bus_cnt_t  cnt;
    bus_data_t ret_sh;
    logic      last_bit;

    // Reads end after the address, writes after the data byte
    assign last_bit = link.data_valid &&
        ((!link.rw && cnt == bus_cnt_t'(`BUS_ADDR_W - 1)) ||
         (link.rw && cnt == bus_cnt_t'(`BUS_ADDR_W + `BUS_DATA_W - 1)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_RECV;
            cnt   <= '0;
        end else begin
            case (state)
                S_RECV: begin
                    if (last_bit) begin
                        cnt   <= '0;
                        state <= S_REQ;
                    end else if (link.data_valid) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_REQ: begin
                    if (tgt_ack) begin
                        state <= tgt_rw ? S_DONE : S_RET;
                    end
                end
                S_RET: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == bus_cnt_t'(`BUS_DATA_W - 1)) begin
                        cnt   <= '0;
                        state <= S_DONE;
                    end
                end
                S_DONE:  state <= S_RECV;
                default: state <= S_RECV;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_RECV && link.data_valid) begin
            tgt_rw <= link.rw;
            if (link.phase == ADDR_PHASE) begin
                tgt_addr <= {tgt_addr[`BUS_ADDR_W-2:0], link.data_bit};
            end else begin
                tgt_wdata <= {tgt_wdata[`BUS_DATA_W-2:0], link.data_bit};
            end
        end
        if (state == S_REQ && tgt_ack) begin
            ret_sh <= tgt_rdata;
        end else if (state == S_RET) begin
            ret_sh <= ret_sh << 1;
        end
    end

    assign tgt_req        = (state == S_REQ);
    assign link.ret_valid = (state == S_RET);
    assign link.ret_bit   = (state == S_RET) && ret_sh[`BUS_DATA_W-1];
    assign link.done      = (state == S_DONE);

endmodule

//--- src/addr_decoder.sv
`timescale 1ns/100ps

module addr_decoder
    import serial_bus_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    serial_link_if.target    shared_link,
    serial_link_if.initiator tgt_link0,
    serial_link_if.initiator tgt_link1
);

    logic        active;
    logic        first_bit;
    target_sel_e sel_q;
    target_sel_e cur_sel;

    assign first_bit = shared_link.data_valid && !active &&
                       (shared_link.phase == ADDR_PHASE);

    // The MSB itself steers the first bit
    assign cur_sel = first_bit ? target_sel_e'(shared_link.data_bit) : sel_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            sel_q  <= TARGET_0;
        end else if (first_bit) begin
            active <= 1'b1;
            sel_q  <= cur_sel;
        end else if (shared_link.done) begin
            active <= 1'b0;
        end
    end

    assign tgt_link0.data_bit   = (cur_sel == TARGET_0) && shared_link.data_bit;
    assign tgt_link0.data_valid = (cur_sel == TARGET_0) && shared_link.data_valid;
    assign tgt_link0.phase      = (cur_sel == TARGET_0) ? shared_link.phase : ADDR_PHASE;
    assign tgt_link0.rw         = (cur_sel == TARGET_0) && shared_link.rw;
    assign tgt_link0.busy       = (cur_sel == TARGET_0) && shared_link.busy;

    assign tgt_link1.data_bit   = (cur_sel == TARGET_1) && shared_link.data_bit;
    assign tgt_link1.data_valid = (cur_sel == TARGET_1) && shared_link.data_valid;
    assign tgt_link1.phase      = (cur_sel == TARGET_1) ? shared_link.phase : ADDR_PHASE;
    assign tgt_link1.rw         = (cur_sel == TARGET_1) && shared_link.rw;
    assign tgt_link1.busy       = (cur_sel == TARGET_1) && shared_link.busy;

    assign shared_link.ret_bit   = (cur_sel == TARGET_1) ? tgt_link1.ret_bit : tgt_link0.ret_bit;
    assign shared_link.ret_valid = (cur_sel == TARGET_1) ? tgt_link1.ret_valid
                                                         : tgt_link0.ret_valid;
    assign shared_link.done      = (cur_sel == TARGET_1) ? tgt_link1.done : tgt_link0.done;

endmodule

//--- src/init_port.sv
`timescale 1ns/100ps
`include "serial_bus_macros.svh"

module init_port
    import serial_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init_req,
    input  bus_addr_t init_addr,
    input  bus_data_t init_wdata,
    input  logic      init_rw,
    input  logic      grant,
    output logic      bus_req,
    output logic      init_ack,
    output bus_data_t init_rdata,
    serial_link_if.initiator link
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        SEND_ADDR,
        SEND_DATA,
        WAIT_DONE,
        ACK,
        RELEASE
    } state_e;

    state_e    state;
    bus_cnt_t  cnt;
    bus_addr_t addr_sh;
    bus_data_t wdata_sh;
    bus_data_t rdata_sh;
    logic      rw_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (init_req) begin
                        state <= WAIT_GRANT;
                    end
                end
                WAIT_GRANT: begin
                    if (grant) begin
                        state <= SEND_ADDR;
                        cnt   <= '0;
                    end
                end
                SEND_ADDR: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == bus_cnt_t'(`BUS_ADDR_W - 1)) begin
                        cnt   <= '0;
                        state <= rw_q ? SEND_DATA : WAIT_DONE;
                    end
                end
                SEND_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == bus_cnt_t'(`BUS_DATA_W - 1)) begin
                        cnt   <= '0;
                        state <= WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    if (link.done) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    if (!init_req) begin
                        state <= RELEASE;
                    end
                end
                // One cycle with ack low before the next capture
                RELEASE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && init_req) begin
            addr_sh  <= init_addr;
            wdata_sh <= init_wdata;
            rw_q     <= init_rw;
        end else if (state == SEND_ADDR) begin
            addr_sh <= addr_sh << 1;
        end else if (state == SEND_DATA) begin
            wdata_sh <= wdata_sh << 1;
        end
        // Read byte arrives MSB first
        if (state == WAIT_DONE && link.ret_valid) begin
            rdata_sh <= {rdata_sh[`BUS_DATA_W-2:0], link.ret_bit};
        end
    end

    assign bus_req    = (state == WAIT_GRANT);
    assign init_ack   = (state == ACK);
    assign init_rdata = rdata_sh;

    assign link.data_valid = (state == SEND_ADDR) || (state == SEND_DATA);
    assign link.data_bit   = (state == SEND_ADDR) ? addr_sh[`BUS_ADDR_W-1]
                                                  : wdata_sh[`BUS_DATA_W-1];
    assign link.phase      = (state == SEND_DATA) ? DATA_PHASE : ADDR_PHASE;
    assign link.rw         = rw_q;
    assign link.busy       = link.data_valid || (state == WAIT_DONE);

endmodule

//--- src/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter
    import serial_bus_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic bus_req0,
    input  logic bus_req1,
    output logic grant0,
    output logic grant1,
    serial_link_if.target    init_link0,
    serial_link_if.target    init_link1,
    serial_link_if.initiator shared_link
);

    logic last_owner;
    logic shared_busy;
    logic hold;

    assign shared_busy = grant0 ? init_link0.busy : (grant1 ? init_link1.busy : 1'b0);

    // Keep the grant while a transfer runs or the owner has not started yet
    assign hold = shared_busy || (grant0 && bus_req0) || (grant1 && bus_req1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant0     <= 1'b0;
            grant1     <= 1'b0;
            last_owner <= 1'b1;
        end else if (!hold) begin
            if (bus_req0 && bus_req1) begin
                grant0     <= last_owner;
                grant1     <= !last_owner;
                last_owner <= !last_owner;
            end else begin
                grant0 <= bus_req0;
                grant1 <= bus_req1;
                if (bus_req0) begin
                    last_owner <= 1'b0;
                end else if (bus_req1) begin
                    last_owner <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        shared_link.data_bit   = 1'b0;
        shared_link.data_valid = 1'b0;
        shared_link.phase      = ADDR_PHASE;
        shared_link.rw         = 1'b0;
        shared_link.busy       = shared_busy;
        init_link0.ret_bit     = 1'b0;
        init_link0.ret_valid   = 1'b0;
        init_link0.done        = 1'b0;
        init_link1.ret_bit     = 1'b0;
        init_link1.ret_valid   = 1'b0;
        init_link1.done        = 1'b0;
        if (grant0) begin
            shared_link.data_bit   = init_link0.data_bit;
            shared_link.data_valid = init_link0.data_valid;
            shared_link.phase      = init_link0.phase;
            shared_link.rw         = init_link0.rw;
            init_link0.ret_bit     = shared_link.ret_bit;
            init_link0.ret_valid   = shared_link.ret_valid;
            init_link0.done        = shared_link.done;
        end else if (grant1) begin
            shared_link.data_bit   = init_link1.data_bit;
            shared_link.data_valid = init_link1.data_valid;
            shared_link.phase      = init_link1.phase;
            shared_link.rw         = init_link1.rw;
            init_link1.ret_bit     = shared_link.ret_bit;
            init_link1.ret_valid   = shared_link.ret_valid;
            init_link1.done        = shared_link.done;
        end
    end

endmodule

//--- src/serial_link_if.sv
`timescale 1ns/100ps

interface serial_link_if
    import serial_bus_pkg::*;
();

    // Forward direction
    logic       data_bit;
    logic       data_valid;
    bus_phase_e phase;
    logic       rw;
    logic       busy;

    // Return direction
    logic       ret_bit;
    logic       ret_valid;
    logic       done;

    modport initiator (
        output data_bit, data_valid, phase, rw, busy,
        input  ret_bit, ret_valid, done
    );

    modport target (
        input  data_bit, data_valid, phase, rw, busy,
        output ret_bit, ret_valid, done
    );

endinterface

//--- src/serial_bus_pkg.sv
`include "serial_bus_macros.svh"

package serial_bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_W-1:0] bus_data_t;
    typedef logic [`BUS_CNT_W-1:0]  bus_cnt_t;

    // Forward bit carries address or write data
    typedef enum logic {
        ADDR_PHASE = 1'b0,
        DATA_PHASE = 1'b1
    } bus_phase_e;

    // Address bit 15 picks the target
    typedef enum logic {
        TARGET_0 = 1'b0,
        TARGET_1 = 1'b1
    } target_sel_e;

endpackage

//--- src/serial_bus_macros.svh
`ifndef SERIAL_BUS_MACROS_SVH
`define SERIAL_BUS_MACROS_SVH

// Transfer address width
`define BUS_ADDR_W 16

// Data byte width
`define BUS_DATA_W 8

// Bit counter wide enough for address plus data
`define BUS_CNT_W 5

`endif
